// File: source/msg_bridge_pkg.sv
package msg_bridge_pkg;

  // ****************************************
  // Message word
  // ****************************************
  localparam int MSG_WIDTH = 32;

  typedef logic [MSG_WIDTH-1:0] msg_t;

  // ****************************************
  // FIFO depths, in words
  // ****************************************
  localparam int WR_FIFO_DEPTH   = 16;
  localparam int RD_FIFO_DEPTH   = 16;
  localparam int LOOP_FIFO_DEPTH = 16;

  // All-ones word that closes a host stream
  localparam msg_t END_MARKER = '1;

endpackage

// File: source/msg_fifo_if.sv
`timescale 1ns/100ps

interface msg_fifo_if;
  import msg_bridge_pkg::*;

  // Write side
  msg_t din;
  logic wr_en;
  logic full;

  // Read side, dout is valid while empty is low
  logic rd_en;
  msg_t dout;
  logic empty;

  modport fifo (
    input  din, wr_en, rd_en,
    output dout, full, empty
  );

  // The writer also watches empty, for the end-of-file checks
  modport writer (
    output din, wr_en,
    input  full, empty
  );

  modport reader (
    output rd_en,
    input  dout, empty
  );

endinterface

// File: source/msg_fifo.sv
`timescale 1ns/100ps

module msg_fifo #(
  parameter int DEPTH = 16
) (
  input logic     bus_clk,
  input logic     rst,
  msg_fifo_if.fifo q
);
  import msg_bridge_pkg::*;

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  msg_t             mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_wr;
  logic             do_rd;

  // Requests that are honored this cycle
  assign do_wr = q.wr_en && !q.full;
  assign do_rd = q.rd_en && !q.empty;

  // ****************************************
  // Status and first-word-fall-through head
  // ****************************************
  assign q.full  = (count == CNT_W'(DEPTH));
  assign q.empty = (count == '0);
  assign q.dout  = mem[rd_ptr];

  // Storage
  always_ff @(posedge bus_clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= q.din;
    end
  end

  // ****************************************
  // Pointers and occupancy
  // ****************************************
  always_ff @(posedge bus_clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        if (wr_ptr == PTR_W'(DEPTH - 1)) begin
          wr_ptr <= '0;
        end else begin
          wr_ptr <= wr_ptr + 1'b1;
        end
      end
      if (do_rd) begin
        if (rd_ptr == PTR_W'(DEPTH - 1)) begin
          rd_ptr <= '0;
        end else begin
          rd_ptr <= rd_ptr + 1'b1;
        end
      end
      // Count only moves when exactly one side acts
      if (do_wr && !do_rd) begin
        count <= count + 1'b1;
      end else if (do_rd && !do_wr) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

// File: source/stream_channel_ctrl.sv
`timescale 1ns/100ps

module stream_channel_ctrl (
  input  logic                  bus_clk,
  input  logic                  rst,

  // Application words towards the host
  input  msg_bridge_pkg::msg_t  fpga_msg,
  input  logic                  fpga_msg_valid,
  input  logic                  rd_open,
  input  logic                  wr_open,
  input  logic                  app_done,

  // FIFO sides
  msg_fifo_if.reader            wr_q,
  msg_fifo_if.writer            rd_q,
  msg_fifo_if.writer            loop_q,

  input  logic                  pc_msg_ack,

  output logic                  rd_eof,
  output logic                  loop_eof
);
  import msg_bridge_pkg::*;

  logic ack_taken;
  logic rd_eof_cond;
  logic loop_eof_cond;

  // ****************************************
  // Host write queue pop and loopback copy
  // ****************************************

  // The ack pops wr_q, an ack on an empty queue does nothing
  assign wr_q.rd_en = pc_msg_ack;
  assign ack_taken  = pc_msg_ack && !wr_q.empty;

  // Every word the application takes is echoed back to the host
  assign loop_q.din   = wr_q.dout;
  assign loop_q.wr_en = ack_taken;

  // ****************************************
  // Read channel gating
  // ****************************************

  // Words offered while the host has the channel closed are dropped
  assign rd_q.din   = fpga_msg;
  assign rd_q.wr_en = fpga_msg_valid && rd_open;

  // ****************************************
  // End-of-file flags
  // ****************************************

  // End marker at the head of the write queue, nothing left to read
  assign rd_eof_cond = (!wr_q.empty && (wr_q.dout == END_MARKER) && rd_q.empty)
                       || app_done;

  // Host closed the write side and the loopback is drained
  assign loop_eof_cond = !wr_open && loop_q.empty;

  always_ff @(posedge bus_clk) begin
    if (rst) begin
      rd_eof   <= 1'b0;
      loop_eof <= 1'b0;
    end else begin
      rd_eof   <= rd_eof_cond;
      loop_eof <= loop_eof_cond;
    end
  end

endmodule

// File: source/msg_bridge_top.sv
`timescale 1ns/100ps

module msg_bridge_top (
  input  logic                  bus_clk,
  input  logic                  rst,

  // Host write channel
  input  msg_bridge_pkg::msg_t  wr_data,
  input  logic                  wr_wren,
  input  logic                  wr_open,
  output logic                  wr_full,

  // Host read channel
  output msg_bridge_pkg::msg_t  rd_data,
  input  logic                  rd_rden,
  input  logic                  rd_open,
  output logic                  rd_empty,
  output logic                  rd_eof,

  // Host loop channel
  output msg_bridge_pkg::msg_t  loop_data,
  input  logic                  loop_rden,
  output logic                  loop_empty,
  output logic                  loop_eof,

  // Application side
  output msg_bridge_pkg::msg_t  pc_msg,
  output logic                  pc_msg_empty,
  input  logic                  pc_msg_ack,
  input  msg_bridge_pkg::msg_t  fpga_msg,
  input  logic                  fpga_msg_valid,
  output logic                  fpga_msg_full,
  input  logic                  app_done
);
  import msg_bridge_pkg::*;

  msg_fifo_if wr_q_if ();
  msg_fifo_if rd_q_if ();
  msg_fifo_if loop_q_if ();

  // ****************************************
  // Host side port mapping
  // ****************************************
  assign wr_q_if.din   = wr_data;
  assign wr_q_if.wr_en = wr_wren;
  assign wr_full       = wr_q_if.full;

  assign rd_data       = rd_q_if.dout;
  assign rd_q_if.rd_en = rd_rden;
  assign rd_empty      = rd_q_if.empty;

  assign loop_data       = loop_q_if.dout;
  assign loop_q_if.rd_en = loop_rden;
  assign loop_empty      = loop_q_if.empty;

  // Application side port mapping
  assign pc_msg        = wr_q_if.dout;
  assign pc_msg_empty  = wr_q_if.empty;
  assign fpga_msg_full = rd_q_if.full;

  // ****************************************
  // FIFOs
  // ****************************************
  msg_fifo #(.DEPTH(WR_FIFO_DEPTH)) wr_q (
    .bus_clk (bus_clk),
    .rst     (rst),
    .q       (wr_q_if.fifo)
  );

  msg_fifo #(.DEPTH(RD_FIFO_DEPTH)) rd_q (
    .bus_clk (bus_clk),
    .rst     (rst),
    .q       (rd_q_if.fifo)
  );

  msg_fifo #(.DEPTH(LOOP_FIFO_DEPTH)) loop_q (
    .bus_clk (bus_clk),
    .rst     (rst),
    .q       (loop_q_if.fifo)
  );

  // Gating, loopback capture and end-of-file flags
  stream_channel_ctrl ctrl (
    .bus_clk        (bus_clk),
    .rst            (rst),
    .fpga_msg       (fpga_msg),
    .fpga_msg_valid (fpga_msg_valid),
    .rd_open        (rd_open),
    .wr_open        (wr_open),
    .app_done       (app_done),
    .wr_q           (wr_q_if.reader),
    .rd_q           (rd_q_if.writer),
    .loop_q         (loop_q_if.writer),
    .pc_msg_ack     (pc_msg_ack),
    .rd_eof         (rd_eof),
    .loop_eof       (loop_eof)
  );

endmodule

// File: tests/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen #(
  parameter int PERIOD       = 40,
  parameter int RESET_CYCLES = 4
) (
  output logic bus_clk,
  output logic rst
);

  // Free running bus clock
  initial begin
    bus_clk = 1'b0;
    forever #(PERIOD / 2) bus_clk = ~bus_clk;
  end

  // Reset held over the first rising edges, released just after an edge
  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge bus_clk);
    #2;
    rst = 1'b0;
  end

endmodule

// File: tests/tb_checker.sv
`timescale 1ns/100ps

module tb_checker (
  input logic                  bus_clk,
  input logic                  rst,
  input msg_bridge_pkg::msg_t  wr_data,
  input logic                  wr_wren,
  input logic                  wr_open,
  input logic                  wr_full,
  input msg_bridge_pkg::msg_t  rd_data,
  input logic                  rd_rden,
  input logic                  rd_open,
  input logic                  rd_empty,
  input logic                  rd_eof,
  input msg_bridge_pkg::msg_t  loop_data,
  input logic                  loop_rden,
  input logic                  loop_empty,
  input logic                  loop_eof,
  input msg_bridge_pkg::msg_t  pc_msg,
  input logic                  pc_msg_empty,
  input logic                  pc_msg_ack,
  input msg_bridge_pkg::msg_t  fpga_msg,
  input logic                  fpga_msg_valid,
  input logic                  fpga_msg_full,
  input logic                  app_done
);
  import msg_bridge_pkg::*;

  // Reference queues for the three FIFOs
  msg_t  wr_model[$];
  msg_t  rd_model[$];
  msg_t  loop_model[$];
  logic  exp_rd_eof;
  logic  exp_loop_eof;
  string test_name   = "reset";
  int    error_count = 0;
  int    check_count = 0;

  task automatic set_test(input string name);
    test_name = name;
  endtask

  task automatic compare_word(input string what, input msg_t exp, input msg_t act);
    check_count++;
    if (act !== exp) begin
      error_count++;
      $display("mismatch in %s: %s expected %h actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic compare_flag(input string what, input logic exp, input logic act);
    check_count++;
    if (act !== exp) begin
      error_count++;
      $display("mismatch in %s: %s expected %b actual %b", test_name, what, exp, act);
    end
  endtask

  // ****************************************
  // Output comparison against the model
  // ****************************************
  task automatic compare_outputs();
    compare_flag("wr_full", wr_model.size() == WR_FIFO_DEPTH, wr_full);
    compare_flag("pc_msg_empty", wr_model.size() == 0, pc_msg_empty);
    if (wr_model.size() > 0) begin
      compare_word("pc_msg", wr_model[0], pc_msg);
    end
    compare_flag("fpga_msg_full", rd_model.size() == RD_FIFO_DEPTH, fpga_msg_full);
    compare_flag("rd_empty", rd_model.size() == 0, rd_empty);
    if (rd_model.size() > 0) begin
      compare_word("rd_data", rd_model[0], rd_data);
    end
    compare_flag("loop_empty", loop_model.size() == 0, loop_empty);
    if (loop_model.size() > 0) begin
      compare_word("loop_data", loop_model[0], loop_data);
    end
    compare_flag("rd_eof", exp_rd_eof, rd_eof);
    compare_flag("loop_eof", exp_loop_eof, loop_eof);
  endtask

  // ****************************************
  // Model step for the coming rising edge
  // ****************************************
  task automatic advance_model();
    logic wr_push;
    logic wr_pop;
    logic rd_push;
    logic rd_pop;
    logic loop_push;
    logic loop_pop;
    logic marker_at_head;
    msg_t head;
    wr_push   = wr_wren && (wr_model.size() < WR_FIFO_DEPTH);
    wr_pop    = pc_msg_ack && (wr_model.size() > 0);
    rd_push   = fpga_msg_valid && rd_open && (rd_model.size() < RD_FIFO_DEPTH);
    rd_pop    = rd_rden && (rd_model.size() > 0);
    loop_push = wr_pop && (loop_model.size() < LOOP_FIFO_DEPTH);
    loop_pop  = loop_rden && (loop_model.size() > 0);
    marker_at_head = 1'b0;
    if (wr_model.size() > 0) begin
      marker_at_head = (wr_model[0] === END_MARKER);
    end
    // Flags registered from the state before the edge
    exp_rd_eof   = (marker_at_head && (rd_model.size() == 0)) || app_done;
    exp_loop_eof = !wr_open && (loop_model.size() == 0);
    if (wr_pop) begin
      head = wr_model.pop_front();
      if (loop_push) begin
        loop_model.push_back(head);
      end
    end
    if (wr_push) begin
      wr_model.push_back(wr_data);
    end
    if (loop_pop) begin
      void'(loop_model.pop_front());
    end
    if (rd_pop) begin
      void'(rd_model.pop_front());
    end
    if (rd_push) begin
      rd_model.push_back(fpga_msg);
    end
  endtask

  // Mid-cycle sampling, inputs and outputs both settled
  always @(negedge bus_clk) begin
    if (rst) begin
      wr_model.delete();
      rd_model.delete();
      loop_model.delete();
      exp_rd_eof   = 1'b0;
      exp_loop_eof = 1'b0;
    end else begin
      compare_outputs();
      advance_model();
    end
  end

endmodule

// File: tests/tb_msg_bridge.sv
`timescale 1ns/100ps

module tb_msg_bridge;
  import msg_bridge_pkg::*;

  localparam int CLK_PERIOD    = 40;
  localparam int DRIVE_DELAY   = 2;
  localparam int SEED          = 32'hd182;
  localparam int NUM_TESTS     = 4;
  localparam int DRAIN_LIMIT   = 80;
  localparam int LOOP_DRAIN_PCT = 85;
  localparam int TOTAL_CYCLES  = 300 + 200 + 250 + 200;
  localparam int WATCHDOG_NS   =
    (TOTAL_CYCLES + NUM_TESTS * (2 * DRAIN_LIMIT + 4) + 100) * CLK_PERIOD;

  logic bus_clk;
  logic rst;
  msg_t wr_data;
  logic wr_wren;
  logic wr_open;
  logic wr_full;
  msg_t rd_data;
  logic rd_rden;
  logic rd_open;
  logic rd_empty;
  logic rd_eof;
  msg_t loop_data;
  logic loop_rden;
  logic loop_empty;
  logic loop_eof;
  msg_t pc_msg;
  logic pc_msg_empty;
  logic pc_msg_ack;
  msg_t fpga_msg;
  logic fpga_msg_valid;
  logic fpga_msg_full;
  logic app_done;

  int          drain_failures = 0;
  int unsigned seed;

  tb_clock_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(4)) clk_gen (
    .bus_clk (bus_clk),
    .rst     (rst)
  );

  msg_bridge_top DUT (.*);

  tb_checker chk (.*);

  task automatic next_cycle();
    @(posedge bus_clk);
    #DRIVE_DELAY;
  endtask

  function automatic logic chance(input int pct);
    return ($urandom % 100) < pct;
  endfunction

  // Random payload that never collides with the end marker
  function automatic msg_t random_word();
    msg_t w;
    w = $urandom;
    if (w == END_MARKER) begin
      w = w ^ 32'h1;
    end
    return w;
  endfunction

  task automatic write_end_marker();
    wr_wren        = 1'b0;
    fpga_msg_valid = 1'b0;
    pc_msg_ack     = 1'b1;
    while (wr_full) begin
      next_cycle();
    end
    pc_msg_ack = 1'b0;
    wr_data    = END_MARKER;
    wr_wren    = 1'b1;
    next_cycle();
    wr_wren = 1'b0;
  endtask

  // ****************************************
  // Drain every queue and close the writer
  // ****************************************
  task automatic drain_all(input string name);
    int   n;
    logic drained;
    drained        = 1'b0;
    wr_wren        = 1'b0;
    fpga_msg_valid = 1'b0;
    app_done       = 1'b0;
    wr_open        = 1'b0;
    pc_msg_ack     = 1'b0;
    rd_rden        = 1'b1;
    loop_rden      = 1'b1;
    // Empty the read FIFO before the end marker reaches the head
    for (n = 0; n < DRAIN_LIMIT && !rd_empty; n++) begin
      next_cycle();
    end
    pc_msg_ack = 1'b1;
    for (n = 0; n < DRAIN_LIMIT && !drained; n++) begin
      next_cycle();
      drained = pc_msg_empty && rd_empty && loop_empty;
    end
    if (!drained) begin
      drain_failures++;
      $display("Test %s: queues did not drain within %0d cycles", name, DRAIN_LIMIT);
    end
    pc_msg_ack = 1'b0;
    rd_rden    = 1'b0;
    loop_rden  = 1'b0;
    next_cycle();
  endtask

  task automatic run_test(
    input string name,
    input int    cycles,
    input int    wr_pct,
    input int    ack_pct,
    input int    offer_pct,
    input int    toggle_pct,
    input int    drain_pct,
    input int    done_from
  );
    int errors_before;
    int drains_before;
    int errs;
    errors_before = chk.error_count;
    drains_before = drain_failures;
    chk.set_test(name);
    wr_open = 1'b1;
    rd_open = 1'b1;
    for (int i = 0; i < cycles; i++) begin
      next_cycle();
      wr_data        = random_word();
      wr_wren        = chance(wr_pct);
      pc_msg_ack     = chance(ack_pct);
      fpga_msg       = $urandom;
      fpga_msg_valid = chance(offer_pct);
      rd_rden        = chance(drain_pct);
      loop_rden      = chance(LOOP_DRAIN_PCT);
      app_done       = (i >= done_from);
      if (chance(toggle_pct)) begin
        rd_open = !rd_open;
      end
      if (chance(toggle_pct)) begin
        wr_open = !wr_open;
      end
    end
    write_end_marker();
    drain_all(name);
    errs = (chk.error_count - errors_before) + (drain_failures - drains_before);
    $display("Test %s finished after %0d cycles with %0d errors", name, cycles, errs);
  endtask

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: run still busy after %0d ns", WATCHDOG_NS);
    $display("Done: errors found");
    $finish;
  end

  initial begin
    int total_errors;
    seed = SEED;
    void'($urandom(seed));
    wr_data        = '0;
    wr_wren        = 1'b0;
    wr_open        = 1'b1;
    rd_rden        = 1'b0;
    rd_open        = 1'b1;
    loop_rden      = 1'b0;
    pc_msg_ack     = 1'b0;
    fpga_msg       = '0;
    fpga_msg_valid = 1'b0;
    app_done       = 1'b0;
    wait (rst == 1'b0);
    next_cycle();

    run_test("basic_flow",         300, 50, 50, 50,  3, 60, 300);
    run_test("write_backpressure", 200, 90, 15, 20,  2, 80, 200);
    run_test("read_gating",        250, 30, 40, 80, 10, 25, 250);
    run_test("app_done_end",       200, 40, 50, 50,  5, 50, 180);

    repeat (2) next_cycle();
    total_errors = chk.error_count + drain_failures;
    $display("Summary: %0d tests, %0d checks, %0d errors",
             NUM_TESTS, chk.check_count, total_errors);
    if (total_errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: build.f
source/msg_bridge_pkg.sv
source/msg_fifo_if.sv
source/msg_fifo.sv
source/stream_channel_ctrl.sv
source/msg_bridge_top.sv
tests/tb_clock_gen.sv
tests/tb_checker.sv
tests/tb_msg_bridge.sv
